// File: hdl/asym_pkg.sv
package asym_pkg;

   // default widths, the top level passes its own values down
   // wide write side, one bus word
   localparam int W_DATA_W_DEF = 32;
   // narrow read side, one stream byte
   localparam int R_DATA_W_DEF = 8;
   // narrow-side address bits, 64 bytes or 16 words
   localparam int ADDR_W_DEF = 6;

   // register select, taken from bus address bit 2
   typedef enum logic {
      REG_DATA   = 1'b0,
      REG_STATUS = 1'b1
   } wb_reg_e;

   // bus-side write FSM
   typedef enum logic [1:0] {
      IDLE       = 2'd0,
      WAIT_SPACE = 2'd1,
      ACK        = 2'd2
   } wr_state_e;

endpackage

// File: hdl/fifo_if.sv
interface fifo_if
   import asym_pkg::*;
#(
   parameter int W_DATA_W = W_DATA_W_DEF,
   parameter int R_DATA_W = R_DATA_W_DEF,
   parameter int ADDR_W   = ADDR_W_DEF
);

   // write side
   logic                push;
   logic [W_DATA_W-1:0] push_data;
   logic                full;
   // level in narrow units, needs one extra bit for a full buffer
   logic [ADDR_W:0]     level;

   // read side
   logic                pop;
   logic [R_DATA_W-1:0] pop_data;
   logic                empty;

   modport producer (output push, output push_data, input full, input level);
   modport fifo (
      input  push, input  push_data, input  pop,
      output full, output level, output pop_data, output empty
   );
   modport consumer (output pop, input pop_data, input empty);

endinterface

// File: hdl/asym_converter.sv
module asym_converter
   import asym_pkg::*;
#(
   parameter int W_DATA_W  = W_DATA_W_DEF,
   parameter int R_DATA_W  = R_DATA_W_DEF,
   parameter int ADDR_W    = ADDR_W_DEF,
   // the narrow side keeps all ADDR_W bits, the wide side drops log2(R)
   localparam int MAXDATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MINDATA_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W,
   localparam int R         = MAXDATA_W / MINDATA_W,
   localparam int MINADDR_W = ADDR_W - $clog2(R),
   localparam int W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                 clk_i,
   input  logic                 reset_i,
   // write port
   input  logic                 w_en_i,
   input  logic [W_ADDR_W-1:0]  w_addr_i,
   input  logic [W_DATA_W-1:0]  w_data_i,
   // read port
   input  logic                 r_en_i,
   input  logic [R_ADDR_W-1:0]  r_addr_i,
   output logic [R_DATA_W-1:0]  r_data_o,
   // banked memory
   output logic [R-1:0]         mem_w_en_o,
   output logic [MINADDR_W-1:0] mem_w_addr_o,
   output logic [MAXDATA_W-1:0] mem_w_data_o,
   output logic [R-1:0]         mem_r_en_o,
   output logic [MINADDR_W-1:0] mem_r_addr_o,
   input  logic [MAXDATA_W-1:0] mem_r_data_i
);

   if (W_DATA_W > R_DATA_W) begin : g_write_wider
      localparam int LOG_R = $clog2(R);

      logic [LOG_R-1:0] r_lsb_q;

      // a whole word lands in every bank on the same edge
      assign mem_w_en_o   = {R{w_en_i}};
      assign mem_w_addr_o = w_addr_i;
      assign mem_w_data_o = w_data_i;

      // low address bits pick one bank for a narrow read
      assign mem_r_en_o   = {{(R - 1){1'b0}}, r_en_i} << r_addr_i[LOG_R-1:0];
      assign mem_r_addr_o = r_addr_i[R_ADDR_W-1:LOG_R];

      // bank select follows the read data by one cycle
      always_ff @(posedge clk_i) begin
         if (reset_i) begin
            r_lsb_q <= '0;
         end else if (r_en_i) begin
            r_lsb_q <= r_addr_i[LOG_R-1:0];
         end
      end

      assign r_data_o = mem_r_data_i[r_lsb_q*R_DATA_W +: R_DATA_W];

   end else if (W_DATA_W < R_DATA_W) begin : g_read_wider
      localparam int LOG_R = $clog2(R);

      // narrow write goes to one bank only
      assign mem_w_en_o   = {{(R - 1){1'b0}}, w_en_i} << w_addr_i[LOG_R-1:0];
      assign mem_w_addr_o = w_addr_i[W_ADDR_W-1:LOG_R];
      // same word on every lane, the enable decides where it sticks
      assign mem_w_data_o = {R{w_data_i}};

      // wide read takes all banks together
      assign mem_r_en_o   = {R{r_en_i}};
      assign mem_r_addr_o = r_addr_i;
      assign r_data_o     = mem_r_data_i;

   end else begin : g_same_width
      assign mem_w_en_o   = w_en_i;
      assign mem_w_addr_o = w_addr_i;
      assign mem_w_data_o = w_data_i;
      assign mem_r_en_o   = r_en_i;
      assign mem_r_addr_o = r_addr_i;
      assign r_data_o     = mem_r_data_i;
   end

endmodule

// File: hdl/banked_ram.sv
module banked_ram #(
   parameter int MAXDATA_W = 32,
   parameter int MINADDR_W = 4,
   parameter int R         = 4
) (
   input  logic                 clk_i,
   // write port, one enable per bank
   input  logic [R-1:0]         w_en_i,
   input  logic [MINADDR_W-1:0] w_addr_i,
   input  logic [MAXDATA_W-1:0] w_data_i,
   // read port, one enable per bank
   input  logic [R-1:0]         r_en_i,
   input  logic [MINADDR_W-1:0] r_addr_i,
   output logic [MAXDATA_W-1:0] r_data_o
);

   localparam int BANK_W = MAXDATA_W / R;
   localparam int DEPTH  = 2 ** MINADDR_W;

   for (genvar b = 0; b < R; b++) begin : g_bank
      logic [BANK_W-1:0] mem [DEPTH];
      logic [BANK_W-1:0] rd_q;

      always_ff @(posedge clk_i) begin
         if (w_en_i[b]) begin
            mem[w_addr_i] <= w_data_i[b*BANK_W +: BANK_W];
         end
         // bank keeps its last read word while idle
         if (r_en_i[b]) begin
            rd_q <= mem[r_addr_i];
         end
      end

      assign r_data_o[b*BANK_W +: BANK_W] = rd_q;
   end

endmodule

// File: hdl/asym_fifo.sv
module asym_fifo
   import asym_pkg::*;
#(
   parameter int W_DATA_W = W_DATA_W_DEF,
   parameter int R_DATA_W = R_DATA_W_DEF,
   parameter int ADDR_W   = ADDR_W_DEF
) (
   input logic  clk_i,
   input logic  reset_i,
   fifo_if.fifo ff
);

   localparam int MAXDATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MINDATA_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W;
   localparam int R         = MAXDATA_W / MINDATA_W;
   localparam int MINADDR_W = ADDR_W - $clog2(R);
   localparam int W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
   localparam int R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
   // narrow units moved by one push and by one pop
   localparam int W_UNITS   = W_DATA_W / MINDATA_W;
   localparam int R_UNITS   = R_DATA_W / MINDATA_W;
   localparam int DEPTH     = 2 ** ADDR_W;
   localparam int LVL_W     = ADDR_W + 1;

   logic                 push_ok;
   logic                 pop_ok;
   // pointers carry one wrap bit above the address
   logic [W_ADDR_W:0]    wr_ptr_q;
   logic [R_ADDR_W:0]    rd_ptr_q;
   logic [LVL_W-1:0]     wr_units;
   logic [LVL_W-1:0]     rd_units;
   logic [LVL_W-1:0]     level;

   logic [R-1:0]         mem_w_en;
   logic [MINADDR_W-1:0] mem_w_addr;
   logic [MAXDATA_W-1:0] mem_w_data;
   logic [R-1:0]         mem_r_en;
   logic [MINADDR_W-1:0] mem_r_addr;
   logic [MAXDATA_W-1:0] mem_r_data;

   assign push_ok = ff.push && !ff.full;
   assign pop_ok  = ff.pop && !ff.empty;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // both pointers scaled to narrow units, wrap bits then line up
   assign wr_units = LVL_W'(wr_ptr_q) << $clog2(W_UNITS);
   assign rd_units = LVL_W'(rd_ptr_q) << $clog2(R_UNITS);
   assign level    = wr_units - rd_units;

   assign ff.level = level;
   // full once a whole write word no longer fits
   assign ff.full  = level > LVL_W'(DEPTH - W_UNITS);
   assign ff.empty = level < LVL_W'(R_UNITS);

   asym_converter #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_converter (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .w_en_i      (push_ok),
      .w_addr_i    (wr_ptr_q[W_ADDR_W-1:0]),
      .w_data_i    (ff.push_data),
      .r_en_i      (pop_ok),
      .r_addr_i    (rd_ptr_q[R_ADDR_W-1:0]),
      .r_data_o    (ff.pop_data),
      .mem_w_en_o  (mem_w_en),
      .mem_w_addr_o(mem_w_addr),
      .mem_w_data_o(mem_w_data),
      .mem_r_en_o  (mem_r_en),
      .mem_r_addr_o(mem_r_addr),
      .mem_r_data_i(mem_r_data)
   );

   banked_ram #(
      .MAXDATA_W(MAXDATA_W),
      .MINADDR_W(MINADDR_W),
      .R        (R)
   ) u_ram (
      .clk_i   (clk_i),
      .w_en_i  (mem_w_en),
      .w_addr_i(mem_w_addr),
      .w_data_i(mem_w_data),
      .r_en_i  (mem_r_en),
      .r_addr_i(mem_r_addr),
      .r_data_o(mem_r_data)
   );

   // producer must hold off while full
   a_no_push_full : assert property (@(posedge clk_i) disable iff (reset_i)
      ff.push |-> !ff.full)
      else $error("push while FIFO full");

   // consumer must not pop an empty buffer
   a_no_pop_empty : assert property (@(posedge clk_i) disable iff (reset_i)
      ff.pop |-> !ff.empty)
      else $error("pop while FIFO empty");

endmodule

// File: hdl/wb_word_writer.sv
module wb_word_writer
   import asym_pkg::*;
#(
   parameter int W_DATA_W = W_DATA_W_DEF
) (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   input  logic [2:2]          wb_adr_i,
   input  logic [W_DATA_W-1:0] wb_dat_i,
   output logic [W_DATA_W-1:0] wb_dat_o,
   output logic                wb_ack_o,
   fifo_if.producer            ff
);

   wr_state_e           state_q;
   wr_state_e           state_d;
   wb_reg_e             reg_sel;
   logic                req;
   logic                data_wr;
   logic [W_DATA_W-1:0] status;

   assign req     = wb_cyc_i && wb_stb_i;
   assign reg_sel = wb_reg_e'(wb_adr_i);
   assign data_wr = wb_we_i && (reg_sel == REG_DATA);

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (req && data_wr) begin
               state_d = WAIT_SPACE;
            end else if (req) begin
               state_d = ACK;
            end
         end
         WAIT_SPACE: begin
            // master gave up the cycle
            if (!req) begin
               state_d = IDLE;
            end else if (!ff.full) begin
               state_d = ACK;
            end
         end
         ACK: begin
            state_d = IDLE;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign wb_ack_o = (state_q == ACK);

   // word goes in on the ack cycle, master still holds the data
   assign ff.push      = wb_ack_o && data_wr;
   assign ff.push_data = wb_dat_i;

   // level in the low bits, flags on top
   always_comb begin
      status             = W_DATA_W'(ff.level);
      status[W_DATA_W-1] = ff.full;
      status[W_DATA_W-2] = (ff.level == '0);
   end

   assign wb_dat_o = (wb_ack_o && !wb_we_i && reg_sel == REG_STATUS) ? status : '0;

   // ack answers a live strobe and lasts one cycle
   a_ack_single : assert property (@(posedge clk_i) disable iff (reset_i)
      wb_ack_o |-> req ##1 !wb_ack_o)
      else $error("bus ack outside a strobe or held for two cycles");

endmodule

// File: hdl/byte_stream_out.sv
module byte_stream_out
   import asym_pkg::*;
#(
   parameter int R_DATA_W = R_DATA_W_DEF
) (
   input  logic                clk_i,
   input  logic                reset_i,
   fifo_if.consumer            ff,
   output logic                m_valid_o,
   output logic [R_DATA_W-1:0] m_data_o,
   input  logic                m_ready_i
);

   // two-entry holding buffer, entry 0 is the head
   logic [R_DATA_W-1:0] hold_q [2];
   logic [1:0]          count_q;
   logic                inflight_q;
   logic                out_fire;
   logic [1:0]          keep_cnt;
   logic [1:0]          occ_after;

   assign out_fire  = m_valid_o && m_ready_i;
   // bytes left once the head leaves, then with the returning pop
   assign keep_cnt  = count_q - 2'(out_fire);
   assign occ_after = keep_cnt + 2'(inflight_q);

   // room for one more byte next cycle
   assign ff.pop = !ff.empty && (occ_after < 2'd2);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         count_q    <= '0;
         inflight_q <= 1'b0;
      end else begin
         count_q    <= occ_after;
         inflight_q <= ff.pop;
      end
   end

   always_ff @(posedge clk_i) begin
      if (out_fire) begin
         hold_q[0] <= hold_q[1];
      end
      // returning byte goes behind whatever stays
      if (inflight_q) begin
         if (keep_cnt == 2'd0) begin
            hold_q[0] <= ff.pop_data;
         end else begin
            hold_q[1] <= ff.pop_data;
         end
      end
   end

   assign m_valid_o = (count_q != 2'd0);
   assign m_data_o  = hold_q[0];

   a_stall_stable : assert property (@(posedge clk_i) disable iff (reset_i)
      m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o))
      else $error("stream byte changed while stalled");

endmodule

// File: hdl/wb2stream_top.sv
module wb2stream_top
   import asym_pkg::*;
#(
   parameter int W_DATA_W = W_DATA_W_DEF,
   parameter int R_DATA_W = R_DATA_W_DEF,
   parameter int ADDR_W   = ADDR_W_DEF
) (
   input  logic                clk_i,
   input  logic                reset_i,
   // wishbone classic slave
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   input  logic [2:2]          wb_adr_i,
   input  logic [W_DATA_W-1:0] wb_dat_i,
   output logic [W_DATA_W-1:0] wb_dat_o,
   output logic                wb_ack_o,
   // byte stream out
   output logic                m_valid_o,
   output logic [R_DATA_W-1:0] m_data_o,
   input  logic                m_ready_i
);

   fifo_if #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) fifo_link ();

   wb_word_writer #(
      .W_DATA_W(W_DATA_W)
   ) u_writer (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .wb_cyc_i(wb_cyc_i),
      .wb_stb_i(wb_stb_i),
      .wb_we_i (wb_we_i),
      .wb_adr_i(wb_adr_i),
      .wb_dat_i(wb_dat_i),
      .wb_dat_o(wb_dat_o),
      .wb_ack_o(wb_ack_o),
      .ff      (fifo_link.producer)
   );

   // words in, bytes out
   asym_fifo #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .ff     (fifo_link.fifo)
   );

   byte_stream_out #(
      .R_DATA_W(R_DATA_W)
   ) u_stream (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .ff       (fifo_link.consumer),
      .m_valid_o(m_valid_o),
      .m_data_o (m_data_o),
      .m_ready_i(m_ready_i)
   );

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen #(
   parameter int PERIOD       = 20,
   parameter int RESET_CYCLES = 5
) (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   // release just after an edge, like every other tb input
   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1;
      reset_o = 1'b0;
   end

endmodule

// File: tests/tb_wb2stream.sv
module tb_wb2stream;

   localparam int    W_DATA_W        = 32;
   localparam int    R_DATA_W        = 8;
   localparam int    ADDR_W          = 6;
   // buffer size in bytes
   localparam int    CAPACITY        = 2 ** ADDR_W;
   localparam int    CYCLES_PER_LINE = 40;
   localparam string STIM_FILE       = "tests/wb2stream_stim.txt";

   logic                clk;
   logic                reset;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   logic [2:2]          wb_adr;
   logic [W_DATA_W-1:0] wb_dat_w;
   logic [W_DATA_W-1:0] wb_dat_r;
   logic                wb_ack;
   logic                m_valid;
   logic [R_DATA_W-1:0] m_data;
   logic                m_ready;

   // parsed stimulus, one entry per operation
   logic [7:0]          op_q [$];
   logic [31:0]         arg_q [$];
   int                  line_q [$];
   // bytes written but not yet seen on the stream
   logic [7:0]          exp_q [$];

   int                  errors = 0;
   int                  checks = 0;
   int                  rx_count = 0;
   int                  rx_target = 0;
   int                  cycle_cnt = 0;
   int                  cycle_limit = 0;
   logic [1:0]          ready_mode = 2'd0;
   integer              seed = 45255;
   integer              rnd;
   logic                stalled_q = 1'b0;
   logic [7:0]          held_byte;
   logic [7:0]          exp_byte;
   logic [31:0]         rdata;
   string               test_name;

   tb_clock_gen #(
      .PERIOD      (20),
      .RESET_CYCLES(5)
   ) u_clock_gen (
      .clk_o  (clk),
      .reset_o(reset)
   );

   wb2stream_top #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) i_dut (
      .clk_i    (clk),
      .reset_i  (reset),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w),
      .wb_dat_o (wb_dat_r),
      .wb_ack_o (wb_ack),
      .m_valid_o(m_valid),
      .m_data_o (m_data),
      .m_ready_i(m_ready)
   );

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
   endtask

   task automatic load_stim();
      int          fd;
      int          n;
      int          line_no;
      string       line;
      logic [7:0]  op;
      logic [31:0] arg;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("could not open stimulus file %s", STIM_FILE);
         errors++;
      end else begin
         line_no = 0;
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n > 0 && line[0] != "#" && line[0] != "\n") begin
               n = $sscanf(line, "%c %h", op, arg);
               if (n == 2) begin
                  op_q.push_back(op);
                  arg_q.push_back(arg);
                  line_q.push_back(line_no);
               end else begin
                  $display("stimulus line %0d could not be parsed", line_no);
                  errors++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // model side of an accepted data write, low byte leaves first
   task automatic push_word(input logic [31:0] word);
      // two bytes may already sit at the stream output
      if (exp_q.size() > CAPACITY - 4 + 2) begin
         $display("%s: word accepted while the buffer had no room", test_name);
         errors++;
      end
      for (int i = 0; i < 4; i++) begin
         exp_q.push_back(word[8*i +: 8]);
      end
   endtask

   // one wishbone classic cycle, ends on the ack
   task automatic bus_cycle(input logic we, input logic adr, input logic [31:0] wdata,
                            output logic [31:0] rd);
      @(posedge clk);
      #1;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = we;
      wb_adr = adr;
      wb_dat_w = wdata;
      @(negedge clk);
      while (!wb_ack) begin
         @(negedge clk);
      end
      rd = wb_dat_r;
      if (we && !adr) begin
         push_word(wdata);
      end
      @(posedge clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
   endtask

   // status word as the register map defines it
   function automatic logic [31:0] status_word_for(input logic [31:0] level);
      logic [31:0] word;
      word = level;
      word[30] = (level == 32'd0);
      word[31] = (level > 32'(CAPACITY - 4));
      return word;
   endfunction

   task automatic drain(input logic [31:0] n);
      rx_target = rx_target + int'(n);
      while (rx_count < rx_target) begin
         @(negedge clk);
      end
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // ready pattern, 0 low, 1 high, 2 random
   always @(posedge clk) begin
      #1;
      if (ready_mode == 2'd2) begin
         rnd = $random(seed);
         m_ready = rnd[0];
      end else begin
         m_ready = (ready_mode == 2'd1);
      end
   end

   // stream monitor, valid and ready are settled by the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         if (stalled_q && !m_valid) begin
            $display("stream dropped valid while stalled");
            errors++;
         end else if (stalled_q && m_data !== held_byte) begin
            report_mismatch("stalled byte", 32'(held_byte), 32'(m_data));
         end
         if (m_valid && m_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
               $display("stream sent a byte that was never written");
               errors++;
            end else begin
               exp_byte = exp_q.pop_front();
               if (m_data !== exp_byte) begin
                  report_mismatch("stream byte", 32'(exp_byte), 32'(m_data));
               end
            end
            rx_count++;
         end
         stalled_q = m_valid && !m_ready;
         held_byte = m_data;
      end
   end

   initial begin
      wait (cycle_limit > 0);
      wait (cycle_cnt >= cycle_limit);
      $display("run stopped after %0d cycles, checks: %0d, errors: %0d",
               cycle_cnt, checks, errors);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = 1'b0;
      wb_dat_w = '0;
      m_ready = 1'b0;
      load_stim();
      cycle_limit = CYCLES_PER_LINE * (op_q.size() + 1);
      wait (!reset);
      @(negedge clk);
      checks++;
      if (m_valid !== 1'b0) begin
         report_mismatch("valid after reset", 32'd0, 32'(m_valid));
      end
      for (int i = 0; i < op_q.size(); i++) begin
         test_name = $sformatf("stim line %0d", line_q[i]);
         case (op_q[i])
            "W": bus_cycle(1'b1, 1'b0, arg_q[i], rdata);
            "T": bus_cycle(1'b1, 1'b1, arg_q[i], rdata);
            "S": begin
               bus_cycle(1'b0, 1'b1, 32'd0, rdata);
               checks++;
               if (rdata !== status_word_for(arg_q[i])) begin
                  report_mismatch(test_name, status_word_for(arg_q[i]), rdata);
               end
            end
            "Z": begin
               bus_cycle(1'b0, 1'b0, 32'd0, rdata);
               checks++;
               if (rdata !== arg_q[i]) begin
                  report_mismatch(test_name, arg_q[i], rdata);
               end
            end
            "D": drain(arg_q[i]);
            "B": ready_mode = arg_q[i][1:0];
            default: begin
               $display("%s has an unknown operation", test_name);
               errors++;
            end
         endcase
      end
      if (exp_q.size() != 0) begin
         $display("%0d written bytes never reached the stream", exp_q.size());
         errors++;
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: tests/wb2stream_stim.txt
# op arg, arg in hex: W data word, T word to status reg, S expected level,
# Z expected data-reg read, D bytes to drain, B ready 0 low 1 high 2 random
S 0
B 1
W 03020100
W 07060504
D 8
S 0
# ready low, two bytes wait at the stream output and leave the level
B 0
W 13121110
S 2
W 17161514
W 1b1a1918
W 1f1e1d1c
S e
W 23222120
W 27262524
W 2b2a2928
W 2f2e2d2c
W 33323130
W 37363534
W 3b3a3938
W 3f3e3d3c
W 43424140
W 47464544
W 4b4a4948
W 4f4e4d4c
S 3e
# seventeenth word waits until the stream drains
B 2
W 53525150
D 44
S 0
W 63626160
W 67666564
W 6b6a6968
W 6f6e6d6c
W 73727170
D 14
S 0
Z 0
B 0
W a5a55a5a
W c3c33c3c
S 6
T deadbeef
S 6
B 1
D 8
S 0

// File: compile.f
hdl/asym_pkg.sv
hdl/fifo_if.sv
hdl/asym_converter.sv
hdl/banked_ram.sv
hdl/asym_fifo.sv
hdl/wb_word_writer.sv
hdl/byte_stream_out.sv
hdl/wb2stream_top.sv
tests/tb_clock_gen.sv
tests/tb_wb2stream.sv

// File: Makefile
# Verilator flow for the wb2stream testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_wb2stream
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the log decides the result
sim: build
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
